//--- Makefile
# Verilator flow for the spy hunter board logic

TB_TOP := tb_spyhunter

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module spyhunter_board_top

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- design/audio_mixer.sv
/*
 * audio mixer
 * adds the scaled sound-board sample into both stereo channels and
 * drives each channel through its own one-bit dac
 */
`include "spyhunter_settings.svh"

`default_nettype none

module audio_mixer (
	input  wire                        clk_sys,
	input  wire                        rst_i,
	input  spyhunter_pkg::sample_t     audio_l_i,
	input  spyhunter_pkg::sample_t     audio_r_i,
	input  spyhunter_pkg::csd_sample_t csd_audio_i,
	output logic                       audio_l_o,
	output logic                       audio_r_o
);
	import spyhunter_pkg::*;

	sample_t mix_l_q;
	sample_t mix_r_q;

	// sum to one bit of headroom, keep the top bits
	function automatic sample_t mix(input sample_t a, input csd_sample_t c);
		logic [`AUDIO_W:0] sum;
		sum = (`AUDIO_W+1)'(a) + ((`AUDIO_W+1)'(c) << `CSD_SHIFT);
		return sum[`AUDIO_W:1];
	endfunction

	always_ff @(posedge clk_sys) begin
		mix_l_q <= mix(audio_l_i, csd_audio_i);
		mix_r_q <= mix(audio_r_i, csd_audio_i);
	end

	sigma_delta_dac #(.SAMPLE_W(`AUDIO_W)) dac_l (
		.clk_sys  (clk_sys),
		.rst_i    (rst_i),
		.sample_i (mix_l_q),
		.dac_o    (audio_l_o)
	);

	sigma_delta_dac #(.SAMPLE_W(`AUDIO_W)) dac_r (
		.clk_sys  (clk_sys),
		.rst_i    (rst_i),
		.sample_i (mix_r_q),
		.dac_o    (audio_r_o)
	);

endmodule

`default_nettype wire

//--- design/reset_sequencer.sv
/*
 * reset sequencer
 * holds the game in reset until a rom has loaded, then adds a
 * single-cycle second reset pulse after the hold countdown
 */
`include "spyhunter_settings.svh"

`default_nettype none

module reset_sequencer (
	input  wire  clk_sys,
	input  wire  rst_i,
	input  wire  dl_active_i,
	input  wire  menu_reset_i,
	input  wire  button_reset_i,
	output logic game_reset_o
);

	logic                             dl_active_q;
	logic                             rom_loaded_q;
	logic [$bits(`RESET_HOLD)-1:0]    count_q;
	logic                             request_w;

	assign request_w = menu_reset_i || button_reset_i || !rom_loaded_q;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			dl_active_q  <= 1'b0;
			rom_loaded_q <= 1'b0;
			count_q      <= `RESET_HOLD;
			game_reset_o <= 1'b1;
		end else begin
			dl_active_q <= dl_active_i;
			// end of a download means a rom is in memory
			if (dl_active_q && !dl_active_i) begin
				rom_loaded_q <= 1'b1;
			end

			if (request_w) begin
				count_q <= `RESET_HOLD;
			end else if (count_q != '0) begin
				count_q <= count_q - 1'b1;
			end

			// the game needs a second reset once it has run for a while
			game_reset_o <= request_w || (count_q == 1);
		end
	end

	a_hold_until_loaded: assert property (@(posedge clk_sys) disable iff (rst_i)
		!rom_loaded_q |-> game_reset_o);

endmodule

`default_nettype wire

//--- design/rom_dl_writer.sv
/*
 * rom download writer
 * turns rising download write strobes into toggle requests on the
 * program port and the 32-bit sprite port, with remapped addresses
 */
`include "spyhunter_settings.svh"

`default_nettype none

module rom_dl_writer (
	input  wire                        clk_sys,
	input  wire                        rst_i,
	input  wire                        dl_active_i,
	input  wire                        dl_wr_i,
	input  spyhunter_pkg::dl_index_t   dl_index_i,
	input  spyhunter_pkg::dl_addr_t    dl_addr_i,
	input  spyhunter_pkg::dl_byte_t    dl_data_i,
	// program port, 8-bit and 16-bit roms
	output logic                       prog_req_o,
	output spyhunter_pkg::mem_addr_t   prog_addr_o,
	output spyhunter_pkg::byte_lanes_t prog_lanes_o,
	output logic                       prog_we_o,
	output spyhunter_pkg::mem_word_t   prog_data_o,
	// sprite port
	output logic                       sprite_req_o,
	output spyhunter_pkg::mem_addr_t   sprite_addr_o,
	output spyhunter_pkg::byte_lanes_t sprite_lanes_o,
	output logic                       sprite_we_o,
	output spyhunter_pkg::mem_word_t   sprite_data_o,
	output logic                       nvram_wr_o
);
	import spyhunter_pkg::*;

	logic     dl_wr_q;
	logic     accept_w;
	logic     wide_w;
	dl_addr_t prog_full_w;
	dl_addr_t sprite_off_w;

	// ====================================================================
	// accept and remap
	// ====================================================================

	// only index 0 is rom data, and only the rising edge of the strobe counts
	assign accept_w = dl_active_i && (dl_index_i == '0) && dl_wr_i && !dl_wr_q;

	// the 16-bit rom interleaves its two halves, bit 14 becomes the lane
	assign wide_w      = dl_addr_i[`WIDE_ROM_BIT];
	assign prog_full_w = wide_w ? {dl_addr_i[24:15], dl_addr_i[13:0], dl_addr_i[14]}
	                            : dl_addr_i;

	// sprite roms merge into 32-bit words: bit 16 picks the word half,
	// bit 15 the byte lane
	assign sprite_off_w = dl_addr_i - `DL_ADDR_W'(`SPRITE_BASE);

	assign prog_we_o   = dl_active_i;
	assign sprite_we_o = dl_active_i;
	assign nvram_wr_o  = dl_wr_i && (dl_index_i == `NVRAM_INDEX);

	// ====================================================================
	// registers
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			dl_wr_q      <= 1'b0;
			prog_req_o   <= 1'b0;
			sprite_req_o <= 1'b0;
		end else begin
			dl_wr_q <= dl_wr_i;
			if (accept_w) begin
				prog_req_o   <= ~prog_req_o;
				sprite_req_o <= ~sprite_req_o;
			end
		end
	end

	// payload, updated in the same cycle as the toggles
	always_ff @(posedge clk_sys) begin
		if (accept_w) begin
			prog_addr_o    <= prog_full_w[`MEM_ADDR_W:1];
			prog_lanes_o   <= {prog_full_w[0], ~prog_full_w[0]};
			prog_data_o    <= {dl_data_i, dl_data_i};
			sprite_addr_o  <= {sprite_off_w[23:17], sprite_off_w[14:0], sprite_off_w[16]};
			sprite_lanes_o <= {sprite_off_w[15], ~sprite_off_w[15]};
			sprite_data_o  <= {dl_data_i, dl_data_i};
		end
	end

	// both memory ports are written in lockstep
	a_req_equal: assert property (@(posedge clk_sys) disable iff (rst_i)
		prog_req_o == sprite_req_o);

	// no toggle without an accepted write on the previous edge
	a_req_cause: assert property (@(posedge clk_sys) disable iff (rst_i)
		$changed(prog_req_o) |-> $past(accept_w));

endmodule

`default_nettype wire

//--- design/sigma_delta_dac.sv
/*
 * first-order sigma-delta dac
 * one-bit output whose density of ones follows the unsigned sample
 */
`include "spyhunter_settings.svh"

`default_nettype none

module sigma_delta_dac #(
	parameter int SAMPLE_W = `AUDIO_W
) (
	input  wire                 clk_sys,
	input  wire                 rst_i,
	input  wire  [SAMPLE_W-1:0] sample_i,
	output logic                dac_o
);

	// one extra bit holds the carry of the last sum
	logic [SAMPLE_W:0] acc_q;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			acc_q <= '0;
		end else begin
			acc_q <= {1'b0, acc_q[SAMPLE_W-1:0]} + {1'b0, sample_i};
		end
	end

	assign dac_o = acc_q[SAMPLE_W];

endmodule

`default_nettype wire

//--- design/spyhunter_board_top.sv
/*
 * spy hunter board top level
 * rom download write path, game reset sequencing and audio output
 */
`default_nettype none

module spyhunter_board_top (
	input  wire                        clk_sys,
	input  wire                        rst_i,
	// rom download stream
	input  wire                        dl_active_i,
	input  wire                        dl_wr_i,
	input  spyhunter_pkg::dl_index_t   dl_index_i,
	input  spyhunter_pkg::dl_addr_t    dl_addr_i,
	input  spyhunter_pkg::dl_byte_t    dl_data_i,
	// reset requests
	input  wire                        menu_reset_i,
	input  wire                        button_reset_i,
	// audio from the game and sound boards
	input  spyhunter_pkg::sample_t     audio_l_i,
	input  spyhunter_pkg::sample_t     audio_r_i,
	input  spyhunter_pkg::csd_sample_t csd_audio_i,
	// program port
	output logic                       prog_req_o,
	output spyhunter_pkg::mem_addr_t   prog_addr_o,
	output spyhunter_pkg::byte_lanes_t prog_lanes_o,
	output logic                       prog_we_o,
	output spyhunter_pkg::mem_word_t   prog_data_o,
	// sprite port
	output logic                       sprite_req_o,
	output spyhunter_pkg::mem_addr_t   sprite_addr_o,
	output spyhunter_pkg::byte_lanes_t sprite_lanes_o,
	output logic                       sprite_we_o,
	output spyhunter_pkg::mem_word_t   sprite_data_o,
	output logic                       nvram_wr_o,
	output logic                       game_reset_o,
	output logic                       audio_l_o,
	output logic                       audio_r_o
);

	// ====================================================================
	// rom download
	// ====================================================================
	rom_dl_writer u_rom_dl_writer (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.dl_active_i    (dl_active_i),
		.dl_wr_i        (dl_wr_i),
		.dl_index_i     (dl_index_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.prog_req_o     (prog_req_o),
		.prog_addr_o    (prog_addr_o),
		.prog_lanes_o   (prog_lanes_o),
		.prog_we_o      (prog_we_o),
		.prog_data_o    (prog_data_o),
		.sprite_req_o   (sprite_req_o),
		.sprite_addr_o  (sprite_addr_o),
		.sprite_lanes_o (sprite_lanes_o),
		.sprite_we_o    (sprite_we_o),
		.sprite_data_o  (sprite_data_o),
		.nvram_wr_o     (nvram_wr_o)
	);

	// ====================================================================
	// game reset
	// ====================================================================
	reset_sequencer u_reset_sequencer (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.dl_active_i    (dl_active_i),
		.menu_reset_i   (menu_reset_i),
		.button_reset_i (button_reset_i),
		.game_reset_o   (game_reset_o)
	);

	// ====================================================================
	// audio
	// ====================================================================
	audio_mixer u_audio_mixer (
		.clk_sys     (clk_sys),
		.rst_i       (rst_i),
		.audio_l_i   (audio_l_i),
		.audio_r_i   (audio_r_i),
		.csd_audio_i (csd_audio_i),
		.audio_l_o   (audio_l_o),
		.audio_r_o   (audio_r_o)
	);

endmodule

`default_nettype wire

//--- design/spyhunter_pkg.sv
/*
 * spy hunter board types
 * vector typedefs shared by the download, reset and audio blocks
 */
`include "spyhunter_settings.svh"

`default_nettype none

package spyhunter_pkg;

	// download stream
	typedef logic [`DL_ADDR_W-1:0]   dl_addr_t;
	typedef logic [7:0]              dl_byte_t;
	typedef logic [7:0]              dl_index_t;

	// memory side, one 16-bit word per address
	typedef logic [`MEM_ADDR_W-1:0]  mem_addr_t;
	// {high byte, low byte} select
	typedef logic [1:0]              byte_lanes_t;
	typedef logic [15:0]             mem_word_t;

	// audio samples
	typedef logic [`AUDIO_W-1:0]     sample_t;
	typedef logic [`CSD_AUDIO_W-1:0] csd_sample_t;

endpackage

`default_nettype wire

//--- design/spyhunter_settings.svh
/*
 * spy hunter board settings
 * widths, download region bases, reset hold time and audio scaling
 */
`ifndef SPYHUNTER_SETTINGS_SVH
`define SPYHUNTER_SETTINGS_SVH

`default_nettype none

// ====================================================================
// download stream and memory ports
// ====================================================================
`define DL_ADDR_W      25
`define MEM_ADDR_W     23
`define SPRITE_BASE    17'h18000
`define WIDE_ROM_BIT   16
`define NVRAM_INDEX    8'hff

// countdown reload for the second reset pulse
`define RESET_HOLD     16'hffff

// ====================================================================
// audio
// ====================================================================
`define AUDIO_W        16
`define CSD_AUDIO_W    10
`define CSD_SHIFT      5

`default_nettype wire

`endif

//--- dv/tb_spyhunter.sv
/*
 * spy hunter board testbench
 * directed tests for the download writer, the reset sequencer and the audio dacs
 */
`include "spyhunter_settings.svh"

`default_nettype none

module tb_spyhunter;
	timeunit 1ns;
	timeprecision 100ps;

	import spyhunter_pkg::*;

	localparam int WAIT_LIMIT = 16;
	localparam int PULSE_LIMIT = 65545;
	localparam int AUDIO_WIN = 65536;

	logic        clk_sys;
	logic        rst_i;
	logic        dl_active_i;
	logic        dl_wr_i;
	dl_index_t   dl_index_i;
	dl_addr_t    dl_addr_i;
	dl_byte_t    dl_data_i;
	logic        menu_reset_i;
	logic        button_reset_i;
	sample_t     audio_l_i;
	sample_t     audio_r_i;
	csd_sample_t csd_audio_i;
	logic        prog_req_o;
	mem_addr_t   prog_addr_o;
	byte_lanes_t prog_lanes_o;
	logic        prog_we_o;
	mem_word_t   prog_data_o;
	logic        sprite_req_o;
	mem_addr_t   sprite_addr_o;
	byte_lanes_t sprite_lanes_o;
	logic        sprite_we_o;
	mem_word_t   sprite_data_o;
	logic        nvram_wr_o;
	logic        game_reset_o;
	logic        audio_l_o;
	logic        audio_r_o;
	logic [31:0] lfsr_q;

	spyhunter_board_top DUT (.*);

	always #4 clk_sys = ~clk_sys;

	// ======================================================================
	// helpers
	// ======================================================================

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// drive one write strobe and report whether the requests toggled
	task automatic write_byte(input dl_index_t idx, input dl_addr_t addr,
			input dl_byte_t data, output logic toggled);
		logic old_req;
		old_req    = prog_req_o;
		dl_index_i = idx;
		dl_addr_i  = addr;
		dl_data_i  = data;
		dl_wr_i    = 1'b1;
		#1;
		check("write_byte nvram strobe", 32'(idx == `NVRAM_INDEX), 32'(nvram_wr_o));
		tick();
		dl_wr_i = 1'b0;
		#1;
		check("write_byte nvram strobe", 32'd0, 32'(nvram_wr_o));
		toggled = 1'b0;
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			if (prog_req_o != old_req) begin
				toggled = 1'b1;
				break;
			end
			tick();
		end
		// strobe stays low one more cycle before the next rise
		tick();
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================
	task automatic after_reset_state();
		check("after_reset_state game_reset", 32'd1, 32'(game_reset_o));
		check("after_reset_state prog_req", 32'd0, 32'(prog_req_o));
		check("after_reset_state sprite_req", 32'd0, 32'(sprite_req_o));
	endtask

	task automatic program_region_writes();
		logic [31:0] r;
		dl_addr_t    addr;
		dl_addr_t    full;
		dl_byte_t    data;
		logic        toggled;
		check("program_region_writes we", 32'd1, 32'(prog_we_o));
		check("program_region_writes sprite we", 32'd1, 32'(sprite_we_o));
		for (int i = 0; i < 16; i++) begin
			take_bits(17, r);
			addr = dl_addr_t'(r[16:0]);
			// alternate between the 8-bit and the 16-bit rom
			addr[16] = i[0];
			if (addr >= `DL_ADDR_W'(`SPRITE_BASE)) begin
				addr[15] = 1'b0;
			end
			take_bits(8, r);
			data = r[7:0];
			write_byte(8'h00, addr, data, toggled);
			if (!toggled) begin
				abort_run("a program region write did not toggle the requests");
			end
			full = addr;
			if (addr[`WIDE_ROM_BIT]) begin
				full[14:1] = addr[13:0];
				full[0]    = addr[14];
			end
			check("program_region_writes addr", 32'(full[`MEM_ADDR_W:1]), 32'(prog_addr_o));
			check("program_region_writes lanes", 32'(full[0] ? 2'b10 : 2'b01),
				32'(prog_lanes_o));
			check("program_region_writes data", 32'({data, data}), 32'(prog_data_o));
			check("program_region_writes req pair", 32'(prog_req_o), 32'(sprite_req_o));
		end
	endtask

	task automatic sprite_region_writes();
		logic [31:0] r;
		dl_addr_t    addr;
		dl_addr_t    s;
		dl_byte_t    data;
		logic        toggled;
		for (int i = 0; i < 16; i++) begin
			take_bits(24, r);
			addr = `DL_ADDR_W'(`SPRITE_BASE) + dl_addr_t'(r[23:0]);
			take_bits(8, r);
			data = r[7:0];
			write_byte(8'h00, addr, data, toggled);
			if (!toggled) begin
				abort_run("a sprite region write did not toggle the requests");
			end
			s = addr - `DL_ADDR_W'(`SPRITE_BASE);
			check("sprite_region_writes addr", 32'({s[23:17], s[14:0], s[16]}),
				32'(sprite_addr_o));
			check("sprite_region_writes lanes", 32'(s[15] ? 2'b10 : 2'b01),
				32'(sprite_lanes_o));
			check("sprite_region_writes data", 32'({data, data}), 32'(sprite_data_o));
		end
	endtask

	task automatic nvram_index_writes();
		logic toggled;
		for (int i = 0; i < 2; i++) begin
			write_byte(`NVRAM_INDEX, dl_addr_t'(i), 8'h5a, toggled);
			check("nvram_index_writes toggle", 32'd0, 32'(toggled));
		end
	endtask

	task automatic reset_release_and_pulse();
		int release_at;
		int pulse_at;
		check("reset_release_and_pulse held", 32'd1, 32'(game_reset_o));
		dl_active_i = 1'b0;
		release_at  = 0;
		for (int n = 1; n <= WAIT_LIMIT; n++) begin
			tick();
			if (!game_reset_o) begin
				release_at = n;
				break;
			end
		end
		if (release_at == 0 || release_at > 4) begin
			abort_run("game reset did not fall within 4 cycles of the download end");
		end
		pulse_at = 0;
		for (int n = 1; n <= PULSE_LIMIT; n++) begin
			tick();
			if (game_reset_o) begin
				pulse_at = n;
				break;
			end
		end
		if (pulse_at < 65530 || pulse_at > 65540) begin
			abort_run("second reset pulse missing or outside 65530 to 65540 cycles");
		end
		// the pulse lasts one cycle and the reset stays low after it
		for (int n = 0; n < 32; n++) begin
			tick();
			check("reset_release_and_pulse after pulse", 32'd0, 32'(game_reset_o));
		end
	endtask

	task automatic inactive_writes();
		logic toggled;
		check("inactive_writes we", 32'd0, 32'(prog_we_o));
		check("inactive_writes sprite we", 32'd0, 32'(sprite_we_o));
		write_byte(8'h00, 25'h00123, 8'hc3, toggled);
		check("inactive_writes toggle", 32'd0, 32'(toggled));
	endtask

	task automatic button_reset_again();
		logic seen;
		button_reset_i = 1'b1;
		seen           = 1'b0;
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			tick();
			if (game_reset_o) begin
				seen = 1'b1;
				break;
			end
		end
		if (!seen) begin
			abort_run("button reset did not raise the game reset");
		end
		button_reset_i = 1'b0;
		seen           = 1'b0;
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			tick();
			if (!game_reset_o) begin
				seen = 1'b1;
				break;
			end
		end
		if (!seen) begin
			abort_run("game reset stayed high after the button was released");
		end
	endtask

	// ones over a full accumulator period equal the mixed sample
	task automatic audio_density(input sample_t l, input sample_t r, input csd_sample_t c);
		logic [`AUDIO_W:0] sum_l;
		logic [`AUDIO_W:0] sum_r;
		int                ones_l;
		int                ones_r;
		sum_l       = {1'b0, l} + {2'b00, c, {`CSD_SHIFT{1'b0}}};
		sum_r       = {1'b0, r} + {2'b00, c, {`CSD_SHIFT{1'b0}}};
		audio_l_i   = l;
		audio_r_i   = r;
		csd_audio_i = c;
		repeat (4) tick();
		ones_l = 0;
		ones_r = 0;
		for (int n = 0; n < AUDIO_WIN; n++) begin
			tick();
			if (audio_l_o) begin
				ones_l++;
			end
			if (audio_r_o) begin
				ones_r++;
			end
		end
		check("audio_density left", 32'(sum_l[`AUDIO_W:1]), 32'(ones_l));
		check("audio_density right", 32'(sum_r[`AUDIO_W:1]), 32'(ones_r));
	endtask

	// ======================================================================
	// sequence
	// ======================================================================
	initial begin
		clk_sys        = 1'b0;
		rst_i          = 1'b1;
		dl_active_i    = 1'b0;
		dl_wr_i        = 1'b0;
		dl_index_i     = '0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		menu_reset_i   = 1'b0;
		button_reset_i = 1'b0;
		audio_l_i      = '0;
		audio_r_i      = '0;
		csd_audio_i    = '0;
		lfsr_q         = 32'h8128;
		repeat (10) @(posedge clk_sys);
		#1;
		rst_i = 1'b0;
		after_reset_state();
		dl_active_i = 1'b1;
		tick();
		program_region_writes();
		sprite_region_writes();
		nvram_index_writes();
		reset_release_and_pulse();
		inactive_writes();
		button_reset_again();
		audio_density(16'h1234, 16'hf00d, 10'h2a5);
		audio_density(16'h0000, 16'hffff, 10'h3ff);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/spyhunter_pkg.sv
design/rom_dl_writer.sv
design/reset_sequencer.sv
design/sigma_delta_dac.sv
design/audio_mixer.sv
design/spyhunter_board_top.sv
dv/tb_spyhunter.sv
